// ==== design/epu_bus_pkg.sv ====
`default_nettype none

// Slave port types shared by the top level and the bus front end
package epu_bus_pkg;

    // Plain vector widths of the burst port
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_id_t;

    // Burst length minus one
    typedef logic [7:0]  bus_len_t;

    // Write address request
    typedef struct packed {
        bus_id_t   id;
        bus_addr_t addr;
        bus_len_t  len;
    } bus_aw_t;

    // Read address request
    typedef struct packed {
        bus_id_t   id;
        bus_addr_t addr;
        bus_len_t  len;
    } bus_ar_t;

    // Write data beat, always a full word
    typedef struct packed {
        bus_data_t data;
        logic      last;
    } bus_w_t;

    // Read data beat
    typedef struct packed {
        bus_id_t   id;
        bus_data_t data;
        logic      last;
    } bus_r_t;

    // Write response, only the id
    typedef struct packed {
        bus_id_t id;
    } bus_b_t;

endpackage

`default_nettype wire

// ==== design/epu_core_pkg.sv ====
`default_nettype none

// Buffer, engine and address map definitions
package epu_core_pkg;

    typedef logic signed [31:0] word_t;
    typedef logic [7:0]         count_t;

    typedef enum logic [0:0] {MODE_MAC, MODE_MAC_RELU} mode_t;

    typedef enum logic [2:0] {
        REG_NONE, REG_INPUT, REG_WEIGHT, REG_BIAS, REG_OUTPUT, REG_CTRL
    } region_t;

    // Largest buffer index width, modules use the low BUF_AW bits
    localparam int BUF_AW_MAX = 8;

    // Region bases, bits 15:12 select the region
    localparam logic [15:0] ADDR_INPUT  = 16'h0000;
    localparam logic [15:0] ADDR_WEIGHT = 16'h1000;
    localparam logic [15:0] ADDR_BIAS   = 16'h2000;
    localparam logic [15:0] ADDR_OUTPUT = 16'h3000;
    localparam logic [15:0] ADDR_CTRL   = 16'h4000;
    localparam logic [15:0] ADDR_STATUS = 16'h4004;

    // Control word fields
    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_COUNT_LSB  = 1;
    localparam int CTRL_MODE_BIT   = 10;
    localparam int STATUS_BUSY_BIT = 0;

    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [BUF_AW_MAX-1:0] idx;
        word_t                 wdata;
    } buf_req_t;

    // Upper address bits must be zero for any region to match
    function automatic region_t decode_region(input logic [31:0] addr);
        if (addr[31:16] != 16'h0000)
            return REG_NONE;
        case ({addr[15:12], 12'h000})
            ADDR_INPUT:  return REG_INPUT;
            ADDR_WEIGHT: return REG_WEIGHT;
            ADDR_BIAS:   return REG_BIAS;
            ADDR_OUTPUT: return REG_OUTPUT;
            ADDR_CTRL:   return REG_CTRL;
            default:     return REG_NONE;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== design/epu_slave_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_slave_port #(
    parameter int BUF_AW = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  epu_bus_pkg::bus_aw_t    aw_i,
    input  logic                    awvalid_i,
    output logic                    awready_o,
    input  epu_bus_pkg::bus_w_t     w_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    output epu_bus_pkg::bus_b_t     b_o,
    output logic                    bvalid_o,
    input  logic                    bready_i,
    input  epu_bus_pkg::bus_ar_t    ar_i,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    output epu_bus_pkg::bus_r_t     r_o,
    output logic                    rvalid_o,
    input  logic                    rready_i,
    output epu_core_pkg::buf_req_t  in_req_o,
    output epu_core_pkg::buf_req_t  wt_req_o,
    output epu_core_pkg::buf_req_t  bs_req_o,
    output epu_core_pkg::buf_req_t  out_req_o,
    input  epu_core_pkg::word_t     in_rdata_i,
    input  epu_core_pkg::word_t     wt_rdata_i,
    input  epu_core_pkg::word_t     bs_rdata_i,
    input  epu_core_pkg::word_t     out_rdata_i,
    output logic                    start_o,
    output epu_core_pkg::count_t    count_o,
    output epu_core_pkg::mode_t     mode_o,
    input  logic                    busy_i
);
    import epu_bus_pkg::*;
    import epu_core_pkg::*;

    typedef enum logic [2:0] {IDLE, W_DATA, B_RESP, R_ISSUE, R_WAIT} state_t;

    state_t    state_q, state_d;
    bus_id_t   id_q;
    bus_addr_t addr_q;
    bus_len_t  len_q;
    bus_len_t  beat_q;
    region_t   region_q;
    word_t     ctl_rdata_q;
    word_t     rdata;
    buf_req_t  bus_req;
    logic [15:0] cur_addr;
    logic      aw_hs, ar_hs, wr_beat, r_hs, last_beat, ctrl_wr;
    logic      start_q;
    count_t    count_q;
    mode_t     mode_q;

    assign awready_o = (state_q == IDLE);
    // A pending write wins over a read in the same cycle
    assign arready_o = (state_q == IDLE) && !awvalid_i;
    assign wready_o  = (state_q == W_DATA);
    assign bvalid_o  = (state_q == B_RESP);
    assign rvalid_o  = (state_q == R_WAIT);

    assign aw_hs     = awvalid_i && awready_o;
    assign ar_hs     = arvalid_i && arready_o;
    assign wr_beat   = wvalid_i && wready_o;
    assign r_hs      = rvalid_o && rready_i;
    assign last_beat = (beat_q == len_q);

    // Byte address of the current beat inside the 64 KB map
    assign cur_addr = addr_q[15:0] + {6'b000000, beat_q, 2'b00};
    assign ctrl_wr  = wr_beat && (region_q == REG_CTRL) && (cur_addr == ADDR_CTRL);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (aw_hs)
                    state_d = W_DATA;
                else if (ar_hs)
                    state_d = R_ISSUE;
            end
            W_DATA:  state_d = (wr_beat && w_i.last) ? B_RESP : W_DATA;
            B_RESP:  state_d = bready_i ? IDLE : B_RESP;
            R_ISSUE: state_d = R_WAIT;
            R_WAIT: begin
                if (r_hs)
                    state_d = last_beat ? IDLE : R_ISSUE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q  <= IDLE;
            beat_q   <= '0;
            region_q <= REG_NONE;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                beat_q   <= '0;
                region_q <= decode_region(aw_i.addr);
            end else if (ar_hs) begin
                beat_q   <= '0;
                region_q <= decode_region(ar_i.addr);
            end else if (wr_beat || r_hs) begin
                beat_q <= beat_q + 8'd1;
            end
        end
    end

    // Burst attributes and the control read word
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q   <= aw_i.id;
            addr_q <= aw_i.addr;
            len_q  <= aw_i.len;
        end else if (ar_hs) begin
            id_q   <= ar_i.id;
            addr_q <= ar_i.addr;
            len_q  <= ar_i.len;
        end
        if (state_q == R_ISSUE) begin
            ctl_rdata_q <= '0;
            if (region_q == REG_CTRL && cur_addr == ADDR_STATUS)
                ctl_rdata_q[STATUS_BUSY_BIT] <= busy_i;
        end
    end

    // Engine control fields, start is a one-cycle pulse
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            start_q <= 1'b0;
            count_q <= '0;
            mode_q  <= MODE_MAC;
        end else begin
            start_q <= 1'b0;
            if (ctrl_wr) begin
                start_q <= w_i.data[CTRL_START_BIT];
                count_q <= w_i.data[CTRL_COUNT_LSB +: $bits(count_t)];
                mode_q  <= mode_t'(w_i.data[CTRL_MODE_BIT]);
            end
        end
    end

    assign start_o = start_q;
    assign count_o = count_q;
    assign mode_o  = mode_q;

    always_comb begin
        bus_req = '0;
        bus_req.en = wr_beat || (state_q == R_ISSUE);
        bus_req.we = wr_beat;
        bus_req.idx[BUF_AW-1:0] = cur_addr[BUF_AW+1:2];
        bus_req.wdata = word_t'(w_i.data);
    end

    // Only the decoded buffer sees the request
    assign in_req_o  = (region_q == REG_INPUT)  ? bus_req : buf_req_t'('0);
    assign wt_req_o  = (region_q == REG_WEIGHT) ? bus_req : buf_req_t'('0);
    assign bs_req_o  = (region_q == REG_BIAS)   ? bus_req : buf_req_t'('0);
    assign out_req_o = (region_q == REG_OUTPUT) ? bus_req : buf_req_t'('0);

    always_comb begin
        case (region_q)
            REG_INPUT:  rdata = in_rdata_i;
            REG_WEIGHT: rdata = wt_rdata_i;
            REG_BIAS:   rdata = bs_rdata_i;
            REG_OUTPUT: rdata = out_rdata_i;
            REG_CTRL:   rdata = ctl_rdata_q;
            default:    rdata = '0;
        endcase
    end

    assign r_o = '{id: id_q, data: bus_data_t'(rdata), last: last_beat};
    assign b_o = '{id: id_q};

endmodule

`default_nettype wire

// ==== design/epu_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_buffer #(
    parameter int BUF_AW = 8
) (
    input  logic                   clk,
    input  epu_core_pkg::buf_req_t bus_req_i,
    input  epu_core_pkg::buf_req_t eng_req_i,
    input  logic                   eng_sel_i,
    output epu_core_pkg::word_t    bus_rdata_o,
    output epu_core_pkg::word_t    eng_rdata_o
);
    import epu_core_pkg::*;

    localparam int DEPTH = 1 << BUF_AW;

    word_t    mem [DEPTH];
    word_t    rdata_q;
    buf_req_t req;
    logic [BUF_AW-1:0] idx;

    // Engine owns the port for the whole run
    assign req = eng_sel_i ? eng_req_i : bus_req_i;
    assign idx = req.idx[BUF_AW-1:0];

    // Single port, write or read per cycle
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we)
                mem[idx] <= req.wdata;
            else
                rdata_q <= mem[idx];
        end
    end

    // Read word holds until the next read access
    assign bus_rdata_o = rdata_q;
    assign eng_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== design/epu_mac_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_mac_engine #(
    parameter int BUF_AW = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  epu_core_pkg::count_t   count_i,
    input  epu_core_pkg::mode_t    mode_i,
    input  epu_core_pkg::word_t    in_rdata_i,
    input  epu_core_pkg::word_t    wt_rdata_i,
    input  epu_core_pkg::word_t    bs_rdata_i,
    output epu_core_pkg::buf_req_t in_req_o,
    output epu_core_pkg::buf_req_t wt_req_o,
    output epu_core_pkg::buf_req_t bs_req_o,
    output epu_core_pkg::buf_req_t out_req_o,
    output logic                   busy_o,
    output logic                   done_o
);
    import epu_core_pkg::*;

    typedef enum logic [1:0] {IDLE, READ, CALC, WRITE} state_t;

    state_t   state_q;
    count_t   idx_q;
    count_t   count_q;
    mode_t    mode_q;
    word_t    result_q;
    word_t    acc;
    logic     done_q;
    logic     last_elem;
    buf_req_t rd_req;
    buf_req_t wr_req;

    assign last_elem = (idx_q == count_q - count_t'(1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
            idx_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        idx_q <= '0;
                        // Empty run finishes right away
                        if (count_i == '0)
                            done_q <= 1'b1;
                        else
                            state_q <= READ;
                    end
                end
                READ:  state_q <= CALC;
                CALC:  state_q <= WRITE;
                WRITE: begin
                    if (last_elem) begin
                        state_q <= IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        state_q <= READ;
                        idx_q   <= idx_q + count_t'(1);
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Run settings are held for the whole pass
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            count_q <= count_i;
            mode_q  <= mode_i;
        end
        if (state_q == CALC)
            result_q <= acc;
    end

    // Product wraps to 32 bits before the bias is added
    always_comb begin
        acc = in_rdata_i * wt_rdata_i;
        acc = acc + bs_rdata_i;
        if (mode_q == MODE_MAC_RELU && acc < 0)
            acc = '0;
    end

    always_comb begin
        rd_req = '0;
        rd_req.en = (state_q == READ);
        rd_req.idx[BUF_AW-1:0] = idx_q[BUF_AW-1:0];
        wr_req = '0;
        wr_req.en = (state_q == WRITE);
        wr_req.we = (state_q == WRITE);
        wr_req.idx[BUF_AW-1:0] = idx_q[BUF_AW-1:0];
        wr_req.wdata = result_q;
    end

    // All three sources are read at the same index
    assign in_req_o  = rd_req;
    assign wt_req_o  = rd_req;
    assign bs_req_o  = rd_req;
    assign out_req_o = wr_req;

    assign busy_o = (state_q != IDLE);
    assign done_o = done_q;

endmodule

`default_nettype wire

// ==== design/epu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_top #(
    parameter int BUF_AW = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  epu_bus_pkg::bus_aw_t aw_i,
    input  logic                 awvalid_i,
    output logic                 awready_o,
    input  epu_bus_pkg::bus_w_t  w_i,
    input  logic                 wvalid_i,
    output logic                 wready_o,
    output epu_bus_pkg::bus_b_t  b_o,
    output logic                 bvalid_o,
    input  logic                 bready_i,
    input  epu_bus_pkg::bus_ar_t ar_i,
    input  logic                 arvalid_i,
    output logic                 arready_o,
    output epu_bus_pkg::bus_r_t  r_o,
    output logic                 rvalid_o,
    input  logic                 rready_i,
    output logic                 done_o
);
    import epu_core_pkg::*;

    // Bus side requests and read data
    buf_req_t in_bus_req, wt_bus_req, bs_bus_req, out_bus_req;
    word_t    in_bus_rdata, wt_bus_rdata, bs_bus_rdata, out_bus_rdata;

    // Engine side requests and read data
    buf_req_t in_eng_req, wt_eng_req, bs_eng_req, out_eng_req;
    word_t    in_eng_rdata, wt_eng_rdata, bs_eng_rdata;

    logic   eng_start, eng_busy;
    count_t eng_count;
    mode_t  eng_mode;

    epu_slave_port #(.BUF_AW(BUF_AW)) u_slave_port (
        .clk        (clk),           .rst        (rst),
        .aw_i       (aw_i),          .awvalid_i  (awvalid_i),    .awready_o (awready_o),
        .w_i        (w_i),           .wvalid_i   (wvalid_i),     .wready_o  (wready_o),
        .b_o        (b_o),           .bvalid_o   (bvalid_o),     .bready_i  (bready_i),
        .ar_i       (ar_i),          .arvalid_i  (arvalid_i),    .arready_o (arready_o),
        .r_o        (r_o),           .rvalid_o   (rvalid_o),     .rready_i  (rready_i),
        .in_req_o   (in_bus_req),    .wt_req_o   (wt_bus_req),
        .bs_req_o   (bs_bus_req),    .out_req_o  (out_bus_req),
        .in_rdata_i (in_bus_rdata),  .wt_rdata_i (wt_bus_rdata),
        .bs_rdata_i (bs_bus_rdata),  .out_rdata_i(out_bus_rdata),
        .start_o    (eng_start),     .count_o    (eng_count),
        .mode_o     (eng_mode),      .busy_i     (eng_busy)
    );

    epu_buffer #(.BUF_AW(BUF_AW)) u_in_buf (
        .clk(clk), .bus_req_i(in_bus_req), .eng_req_i(in_eng_req), .eng_sel_i(eng_busy),
        .bus_rdata_o(in_bus_rdata), .eng_rdata_o(in_eng_rdata)
    );

    epu_buffer #(.BUF_AW(BUF_AW)) u_wt_buf (
        .clk(clk), .bus_req_i(wt_bus_req), .eng_req_i(wt_eng_req), .eng_sel_i(eng_busy),
        .bus_rdata_o(wt_bus_rdata), .eng_rdata_o(wt_eng_rdata)
    );

    epu_buffer #(.BUF_AW(BUF_AW)) u_bs_buf (
        .clk(clk), .bus_req_i(bs_bus_req), .eng_req_i(bs_eng_req), .eng_sel_i(eng_busy),
        .bus_rdata_o(bs_bus_rdata), .eng_rdata_o(bs_eng_rdata)
    );

    // Engine only writes the output buffer
    epu_buffer #(.BUF_AW(BUF_AW)) u_out_buf (
        .clk(clk), .bus_req_i(out_bus_req), .eng_req_i(out_eng_req), .eng_sel_i(eng_busy),
        .bus_rdata_o(out_bus_rdata), .eng_rdata_o()
    );

    epu_mac_engine #(.BUF_AW(BUF_AW)) u_mac_engine (
        .clk        (clk),           .rst        (rst),
        .start_i    (eng_start),     .count_i    (eng_count),    .mode_i    (eng_mode),
        .in_rdata_i (in_eng_rdata),  .wt_rdata_i (wt_eng_rdata), .bs_rdata_i(bs_eng_rdata),
        .in_req_o   (in_eng_req),    .wt_req_o   (wt_eng_req),
        .bs_req_o   (bs_eng_req),    .out_req_o  (out_eng_req),
        .busy_o     (eng_busy),      .done_o     (done_o)
    );

endmodule

`default_nettype wire

// ==== test/epu_tb_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_tb_assert (
    input logic                 clk,
    input logic                 rst,
    input epu_bus_pkg::bus_aw_t aw_i,
    input logic                 awvalid_i,
    input logic                 awready_o,
    input epu_bus_pkg::bus_w_t  w_i,
    input logic                 wvalid_i,
    input logic                 wready_o,
    input epu_bus_pkg::bus_b_t  b_o,
    input logic                 bvalid_o,
    input logic                 bready_i,
    input epu_bus_pkg::bus_ar_t ar_i,
    input logic                 arvalid_i,
    input logic                 arready_o,
    input epu_bus_pkg::bus_r_t  r_o,
    input logic                 rvalid_o,
    input logic                 rready_i
);

    // Requests hold until accepted
    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid_i && !awready_o |=> awvalid_i && $stable(aw_i))
        else $error("AW request dropped or changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rst)
        wvalid_i && !wready_o |=> wvalid_i && $stable(w_i))
        else $error("W beat dropped or changed before wready");

    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid_i && !arready_o |=> arvalid_i && $stable(ar_i))
        else $error("AR request dropped or changed before arready");

    // Responses hold with stable payload under stalls
    b_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid_o && !bready_i |=> bvalid_o && $stable(b_o))
        else $error("B response dropped or changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid_o && !rready_i |=> rvalid_o && $stable(r_o))
        else $error("R beat dropped or changed before rready");

    rst_quiet: assert property (@(posedge clk) !rst |-> !bvalid_o && !rvalid_o)
        else $error("Response valid high during reset");

endmodule

bind epu_slave_port epu_tb_assert u_tb_assert (
    .clk(clk), .rst(rst),
    .aw_i(aw_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
    .w_i(w_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
    .b_o(b_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
    .ar_i(ar_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
    .r_o(r_o), .rvalid_o(rvalid_o), .rready_i(rready_i)
);

`default_nettype wire

// ==== test/epu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module epu_tb;
    import epu_bus_pkg::*;
    import epu_core_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_RAND       = 12;
    localparam int MAX_RAND_LEN = 64;
    // Fills, random pairs, unmapped checks, full readbacks and two engine runs
    localparam int TOTAL_BEATS  = 4 * 256 + 2 * N_RAND * MAX_RAND_LEN + 32 + 4 * 256 + 2 * 259;
    localparam int TOTAL_BURSTS = 4 + 2 * N_RAND + 5 + 4 + 2 * 4;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 6 * TOTAL_BEATS + 10 * TOTAL_BURSTS
                                    + 2 * (3 * 256 + 1);

    logic    clk, rst;
    bus_aw_t aw_i;
    bus_w_t  w_i;
    bus_b_t  b_o;
    bus_ar_t ar_i;
    bus_r_t  r_o;
    logic    awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
    logic    arvalid_i, arready_o, rvalid_o, rready_i, done_o;

    // Reference copy of input, weight, bias and output buffers
    word_t       mdl [4][256];
    logic [31:0] lcg_state = 32'd94;
    int          word_errs = 0;
    int          id_errs = 0;
    int          last_errs = 0;
    int          other_errs = 0;
    int          done_cnt = 0;
    int          cycle_cnt = 0;

    epu_top #(.BUF_AW(8)) dut0 (
        .clk(clk), .rst(rst),
        .aw_i(aw_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
        .w_i(w_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
        .b_o(b_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
        .ar_i(ar_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
        .r_o(r_o), .rvalid_o(rvalid_o), .rready_i(rready_i),
        .done_o(done_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (done_o)
            done_cnt <= done_cnt + 1;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return (r >> 8) % n;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            word_errs++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_id(string name, bus_id_t got, bus_id_t exp);
        if (got !== exp) begin
            id_errs++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_last(string name, logic got, logic exp);
        if (got !== exp) begin
            last_errs++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // Each transfer completes on the rising edge after valid and ready are both seen high
    task automatic write_burst(bus_id_t id, bus_addr_t addr, word_t data_q[$]);
        logic accepted;
        @(negedge clk);
        aw_i = '{id: id, addr: addr, len: bus_len_t'(data_q.size() - 1)};
        awvalid_i = 1'b1;
        while (!awready_o)
            @(negedge clk);
        @(negedge clk);
        awvalid_i = 1'b0;
        foreach (data_q[i]) begin
            repeat (rand_below(3))
                @(negedge clk);
            w_i = '{data: bus_data_t'(data_q[i]), last: (i == data_q.size() - 1)};
            wvalid_i = 1'b1;
            while (!wready_o)
                @(negedge clk);
            @(negedge clk);
            wvalid_i = 1'b0;
        end
        accepted = 1'b0;
        while (!accepted) begin
            bready_i = (rand_below(4) != 0);
            accepted = bvalid_o && bready_i;
            if (!accepted)
                @(negedge clk);
        end
        check_id("bid", b_o.id, id);
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    task automatic read_burst(bus_id_t id, bus_addr_t addr, word_t exp_q[$]);
        int beat;
        @(negedge clk);
        ar_i = '{id: id, addr: addr, len: bus_len_t'(exp_q.size() - 1)};
        arvalid_i = 1'b1;
        while (!arready_o)
            @(negedge clk);
        @(negedge clk);
        arvalid_i = 1'b0;
        beat = 0;
        while (beat < exp_q.size()) begin
            rready_i = (rand_below(4) != 0);
            if (rvalid_o && rready_i) begin
                check_word($sformatf("rdata[%0d]", beat), word_t'(r_o.data), exp_q[beat]);
                check_id("rid", r_o.id, id);
                check_last("rlast", r_o.last, beat == exp_q.size() - 1);
                beat++;
            end
            @(negedge clk);
        end
        rready_i = 1'b0;
    endtask

    // Region r is 0 input, 1 weight, 2 bias, 3 output
    task automatic write_buffer(int r, int start, int len);
        word_t data_q[$];
        word_t d;
        for (int i = 0; i <= len; i++) begin
            d = word_t'(next_rand());
            data_q.push_back(d);
            mdl[r][(start + i) % 256] = d;
        end
        write_burst(bus_id_t'(rand_below(16)), bus_addr_t'(r * 4096 + start * 4), data_q);
    endtask

    task automatic read_buffer(int r, int start, int len);
        word_t exp_q[$];
        for (int i = 0; i <= len; i++)
            exp_q.push_back(mdl[r][(start + i) % 256]);
        read_burst(bus_id_t'(rand_below(16)), bus_addr_t'(r * 4096 + start * 4), exp_q);
    endtask

    task automatic run_engine(mode_t mode);
        int    count;
        int    dones;
        word_t acc;
        word_t ctrl_q[$];
        word_t busy_q[$];
        word_t idle_q[$];
        count = 32 + int'(rand_below(200));
        dones = done_cnt;
        ctrl_q.push_back(word_t'(1 | (count << 1) | (int'(mode) << 10)));
        busy_q.push_back(word_t'(1));
        idle_q.push_back(word_t'(0));
        write_burst(bus_id_t'(rand_below(16)), 32'h0000_4000, ctrl_q);
        read_burst(bus_id_t'(rand_below(16)), 32'h0000_4004, busy_q);
        while (done_cnt == dones)
            @(negedge clk);
        read_burst(bus_id_t'(rand_below(16)), 32'h0000_4004, idle_q);
        if (done_cnt != dones + 1) begin
            other_errs++;
            $display("The engine signalled done more than once for a single run");
        end
        // Only words below count are rewritten
        for (int k = 0; k < count; k++) begin
            acc = mdl[0][k] * mdl[1][k] + mdl[2][k];
            if (mode == MODE_MAC_RELU && acc < 0)
                acc = '0;
            mdl[3][k] = acc;
        end
        read_buffer(3, 0, 255);
    endtask

    initial begin
        int    r;
        int    start;
        int    len;
        int    total;
        word_t junk_q[$];
        word_t zero_q[$];
        clk = 1'b0;
        rst = 1'b0;
        aw_i = '0;
        awvalid_i = 1'b0;
        w_i = '0;
        wvalid_i = 1'b0;
        bready_i = 1'b0;
        ar_i = '0;
        arvalid_i = 1'b0;
        rready_i = 1'b0;
        repeat (RESET_CYCLES)
            @(negedge clk);
        rst = 1'b1;

        for (int b = 0; b < 4; b++)
            write_buffer(b, 0, 255);
        for (int n = 0; n < N_RAND; n++) begin
            r = int'(rand_below(3));
            start = int'(rand_below(256));
            len = int'(rand_below(MAX_RAND_LEN));
            write_buffer(r, start, len);
            read_buffer(r, start, len);
        end

        // Unmapped writes must leave every buffer alone
        for (int i = 0; i < 8; i++)
            junk_q.push_back(word_t'(next_rand()));
        for (int i = 0; i < 4; i++)
            zero_q.push_back('0);
        write_burst(bus_id_t'(rand_below(16)), 32'h0001_0000, junk_q);
        write_burst(bus_id_t'(rand_below(16)), 32'h0000_5000, junk_q);
        read_burst(bus_id_t'(rand_below(16)), 32'h0000_5000, zero_q);
        read_burst(bus_id_t'(rand_below(16)), 32'h0002_0000, zero_q);
        zero_q = '{word_t'(0)};
        read_burst(bus_id_t'(rand_below(16)), 32'h0000_4000, zero_q);
        for (int b = 0; b < 4; b++)
            read_buffer(b, 0, 255);

        run_engine(MODE_MAC);
        run_engine(MODE_MAC_RELU);

        total = word_errs + id_errs + last_errs + other_errs;
        $display("Errors: data %0d, id %0d, last %0d, other %0d",
                 word_errs, id_errs, last_errs, other_errs);
        if (total == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== epu_top.f ====
design/epu_bus_pkg.sv
design/epu_core_pkg.sv
design/epu_slave_port.sv
design/epu_buffer.sv
design/epu_mac_engine.sv
design/epu_top.sv
test/epu_tb_assert.sv
test/epu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the EPU testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module epu_tb -f epu_top.f -o epu_sim

./obj_dir/epu_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
echo "Simulation finished without errors"
exit 0
